// File: rtl/video_pkg.sv
package video_pkg;

    // ------------------------------
    // Horizontal raster in pixels
    // ------------------------------
    localparam int h_visible = 640;
    localparam int h_front   = 16;
    localparam int h_sync    = 96;
    localparam int h_whole   = 800;

    // ------------------------------
    // Vertical raster in lines
    // ------------------------------
    localparam int v_visible = 480;
    localparam int v_front   = 10;
    localparam int v_sync    = 2;
    localparam int v_whole   = 525;

    // Sync windows follow the front porch
    localparam int hs_start = h_visible + h_front;
    localparam int hs_stop  = hs_start + h_sync;
    localparam int vs_start = v_visible + v_front;
    localparam int vs_stop  = vs_start + v_sync;

    // ------------------------------
    // Picture window and console strobes
    // ------------------------------
    localparam int win_left  = 64;
    localparam int win_right = 576;
    localparam int ppu_dots  = 341;
    localparam int cpu_ratio = 3;

    // Each PPU dot spans two pixels
    localparam int ppu_span_end = win_left + 2 * ppu_dots;
    localparam int cpu_cnt_w    = $clog2(cpu_ratio);

    // Pixel rate is osc_clock / 4
    localparam int pix_div_bits = 2;
    // Divider value on which pix_ce fires; vga_clock rises at the following edge
    localparam int pix_ce_phase = 1;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int coord_w   = 10;
    localparam int color_w   = 16;
    localparam int pal_idx_w = 5;
    localparam int red_w     = 5;
    localparam int green_w   = 6;
    localparam int blue_w    = 5;

    localparam int pal_depth = 1 << pal_idx_w;
    // Window is split into pal_depth bars of equal width
    localparam int bar_shift = $clog2((win_right - win_left) / pal_depth);

    // ------------------------------
    // Wishbone and register map
    // ------------------------------
    localparam int wb_addr_w = 8;
    localparam int wb_data_w = 16;

    localparam logic [wb_addr_w-1:0] reg_pal_base = 8'h00;
    localparam logic [wb_addr_w-1:0] reg_border   = 8'h20;
    localparam logic [wb_addr_w-1:0] reg_ctrl     = 8'h21;

    // Control register bit for video enable
    localparam int ctrl_en_bit = 0;

endpackage

// File: rtl/wb_video_regs.sv
`timescale 1ns/100ps

module wb_video_regs (
    input  logic                            osc_clock,
    input  logic                            rst_n,
    input  logic                            wb_cyc,
    input  logic                            wb_stb,
    input  logic                            wb_we,
    input  logic [video_pkg::wb_addr_w-1:0] wb_adr,
    input  logic [video_pkg::wb_data_w-1:0] wb_dat_i,
    input  logic [video_pkg::pal_idx_w-1:0] pal_index,
    output logic [video_pkg::wb_data_w-1:0] wb_dat_o,
    output logic                            wb_ack,
    output logic [video_pkg::color_w-1:0]   pal_color,
    output logic [video_pkg::color_w-1:0]   border_color,
    output logic                            video_en
);
    import video_pkg::*;

    logic                 access;
    logic                 wr_en;
    logic                 pal_sel;
    logic                 border_sel;
    logic                 ctrl_sel;
    logic [pal_idx_w-1:0] wb_pal_idx;
    logic [wb_data_w-1:0] rd_data;

    // Palette RAM
    logic [color_w-1:0]   pal_mem [pal_depth];

    // ------------------------------
    // Bus handshake
    // ------------------------------

    // New access seen while no ack is pending
    // Ack blocks a second sample of the same cycle
    assign access = wb_cyc && wb_stb && !wb_ack;
    assign wr_en  = access && wb_we;

    always_ff @(posedge osc_clock or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            // Ack one clock after the request, drops with stb
            wb_ack <= access;
        end
    end

    // ------------------------------
    // Address decode
    // ------------------------------

    // Palette fills the low pal_depth addresses above its base
    assign pal_sel    = (wb_adr[wb_addr_w-1:pal_idx_w] ==
                         reg_pal_base[wb_addr_w-1:pal_idx_w]);
    assign border_sel = (wb_adr == reg_border);
    assign ctrl_sel   = (wb_adr == reg_ctrl);
    assign wb_pal_idx = wb_adr[pal_idx_w-1:0];

    // Read mux
    // Unmapped addresses read back as zero
    always_comb begin
        rd_data = '0;
        if (pal_sel) begin
            rd_data = pal_mem[wb_pal_idx];
        end else if (border_sel) begin
            rd_data = border_color;
        end else if (ctrl_sel) begin
            rd_data[ctrl_en_bit] = video_en;
        end
    end

    // ------------------------------
    // Storage
    // ------------------------------

    // Palette starts out black
    always_ff @(posedge osc_clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < pal_depth; i++) begin
                pal_mem[i] <= '0;
            end
        end else if (wr_en && pal_sel) begin
            pal_mem[wb_pal_idx] <= wb_dat_i;
        end
    end

    // Border colour and control bits
    always_ff @(posedge osc_clock or negedge rst_n) begin
        if (!rst_n) begin
            border_color <= '0;
            video_en     <= 1'b0;
        end else if (wr_en) begin
            if (border_sel) begin
                border_color <= wb_dat_i;
            end
            if (ctrl_sel) begin
                video_en <= wb_dat_i[ctrl_en_bit];
            end
        end
    end

    // Read data lands together with ack
    always_ff @(posedge osc_clock) begin
        if (access && !wb_we) begin
            wb_dat_o <= rd_data;
        end
    end

    // Second read port for the pixel path
    // Asynchronous, so a palette write shows on the next registered pixel
    assign pal_color = pal_mem[pal_index];

endmodule

// File: rtl/raster_timing.sv
`timescale 1ns/100ps

module raster_timing (
    input  logic                          osc_clock,
    input  logic                          rst_n,
    output logic                          pix_ce,
    output logic [video_pkg::coord_w-1:0] x,
    output logic [video_pkg::coord_w-1:0] y,
    output logic                          vga_clock,
    output logic                          ppu_strobe,
    output logic                          cpu_strobe
);
    import video_pkg::*;

    logic [pix_div_bits-1:0] div;
    logic                    line_end;
    logic                    frame_end;
    logic                    in_span;
    logic [coord_w-1:0]      span_off;
    logic                    ppu_hit;
    logic [cpu_cnt_w-1:0]    cpu_cnt;

    // ------------------------------
    // Oscillator divider
    // ------------------------------

    always_ff @(posedge osc_clock or negedge rst_n) begin
        if (!rst_n) begin
            div <= '0;
        end else begin
            div <= div + 1'b1;
        end
    end

    // One osc cycle in four
    assign pix_ce = (div == pix_div_bits'(pix_ce_phase));

    // Square wave for the monitor at the pixel rate
    // Rises at the edge where pix_ce registers take effect
    assign vga_clock = div[pix_div_bits-1];

    // ------------------------------
    // Raster counters
    // ------------------------------

    assign line_end  = (x == coord_w'(h_whole - 1));
    assign frame_end = (y == coord_w'(v_whole - 1));

    always_ff @(posedge osc_clock or negedge rst_n) begin
        if (!rst_n) begin
            x <= '0;
            y <= '0;
        end else if (pix_ce) begin
            if (line_end) begin
                x <= '0;
                y <= frame_end ? '0 : y + 1'b1;
            end else begin
                x <= x + 1'b1;
            end
        end
    end

    // ------------------------------
    // Console strobes
    // ------------------------------

    // PPU dots only on even lines
    assign in_span  = (x >= coord_w'(win_left)) && (x < coord_w'(ppu_span_end));
    assign span_off = x - coord_w'(win_left);
    // Every second pixel of the span, counted from its first column
    assign ppu_hit  = !y[0] && in_span && !span_off[0];

    always_ff @(posedge osc_clock or negedge rst_n) begin
        if (!rst_n) begin
            ppu_strobe <= 1'b0;
            cpu_strobe <= 1'b0;
            cpu_cnt    <= '0;
        end else begin
            // Single osc-cycle pulses following the pixel enable
            ppu_strobe <= pix_ce && ppu_hit;
            // CPU takes the first dot of each group of three
            cpu_strobe <= pix_ce && ppu_hit && (cpu_cnt == '0);

            if (pix_ce) begin
                if (line_end) begin
                    // 341 is not a multiple of 3, so restart per line
                    cpu_cnt <= '0;
                end else if (ppu_hit) begin
                    if (cpu_cnt == cpu_cnt_w'(cpu_ratio - 1)) begin
                        cpu_cnt <= '0;
                    end else begin
                        cpu_cnt <= cpu_cnt + 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: rtl/pixel_output.sv
`timescale 1ns/100ps

module pixel_output (
    input  logic                            osc_clock,
    input  logic                            rst_n,
    input  logic                            pix_ce,
    input  logic [video_pkg::coord_w-1:0]   x,
    input  logic [video_pkg::coord_w-1:0]   y,
    input  logic [video_pkg::color_w-1:0]   pal_color,
    input  logic [video_pkg::color_w-1:0]   border_color,
    input  logic                            video_en,
    output logic [video_pkg::pal_idx_w-1:0] pal_index,
    output logic [video_pkg::red_w-1:0]     red,
    output logic [video_pkg::green_w-1:0]   green,
    output logic [video_pkg::blue_w-1:0]    blue,
    output logic                            hs,
    output logic                            vs
);
    import video_pkg::*;

    logic               visible;
    logic               in_win;
    logic [coord_w-1:0] win_off;
    logic [color_w-1:0] color;
    logic               hs_win;
    logic               vs_win;

    // ------------------------------
    // Pixel classification
    // ------------------------------

    assign visible = (x < coord_w'(h_visible)) && (y < coord_w'(v_visible));

    // Window is 512 columns centred by the left border
    assign in_win  = video_en && (x >= coord_w'(win_left)) && (x < coord_w'(win_right));

    // Bar number from the window column
    // Outside the window the index is don't-care
    assign win_off   = x - coord_w'(win_left);
    assign pal_index = win_off[bar_shift +: pal_idx_w];

    always_comb begin
        if (!visible) begin
            // Monitor needs black during blanking
            color = '0;
        end else if (in_win) begin
            color = pal_color;
        end else begin
            color = border_color;
        end
    end

    // Active high syncs
    assign hs_win = (x >= coord_w'(hs_start)) && (x < coord_w'(hs_stop));
    assign vs_win = (y >= coord_w'(vs_start)) && (y < coord_w'(vs_stop));

    // ------------------------------
    // Output registers
    // ------------------------------

    // One pixel period behind the counters, all five aligned
    always_ff @(posedge osc_clock or negedge rst_n) begin
        if (!rst_n) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
            hs    <= 1'b0;
            vs    <= 1'b0;
        end else if (pix_ce) begin
            // RGB565 split
            {red, green, blue} <= color;
            hs                 <= hs_win;
            vs                 <= vs_win;
        end
    end

endmodule

// File: rtl/video_top.sv
`timescale 1ns/100ps

module video_top (
    input  logic                            osc_clock,
    input  logic                            rst_n,
    input  logic                            wb_cyc,
    input  logic                            wb_stb,
    input  logic                            wb_we,
    input  logic [video_pkg::wb_addr_w-1:0] wb_adr,
    input  logic [video_pkg::wb_data_w-1:0] wb_dat_i,
    output logic [video_pkg::wb_data_w-1:0] wb_dat_o,
    output logic                            wb_ack,
    output logic                            vga_clock,
    output logic                            ppu_strobe,
    output logic                            cpu_strobe,
    output logic [video_pkg::red_w-1:0]     red,
    output logic [video_pkg::green_w-1:0]   green,
    output logic [video_pkg::blue_w-1:0]    blue,
    output logic                            hs,
    output logic                            vs
);
    import video_pkg::*;

    // Raster position and enable
    logic                 pix_ce;
    logic [coord_w-1:0]   x;
    logic [coord_w-1:0]   y;

    // Palette lookup and register values
    logic [pal_idx_w-1:0] pal_index;
    logic [color_w-1:0]   pal_color;
    logic [color_w-1:0]   border_color;
    logic                 video_en;

    // ------------------------------
    // Host register decode
    // ------------------------------
    wb_video_regs u_regs (
        .osc_clock    (osc_clock),
        .rst_n        (rst_n),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_i     (wb_dat_i),
        .pal_index    (pal_index),
        .wb_dat_o     (wb_dat_o),
        .wb_ack       (wb_ack),
        .pal_color    (pal_color),
        .border_color (border_color),
        .video_en     (video_en)
    );

    // ------------------------------
    // Raster and console timing
    // ------------------------------
    raster_timing u_raster (
        .osc_clock  (osc_clock),
        .rst_n      (rst_n),
        .pix_ce     (pix_ce),
        .x          (x),
        .y          (y),
        .vga_clock  (vga_clock),
        .ppu_strobe (ppu_strobe),
        .cpu_strobe (cpu_strobe)
    );

    // ------------------------------
    // Pixel colour and sync out
    // ------------------------------
    pixel_output u_pixel (
        .osc_clock    (osc_clock),
        .rst_n        (rst_n),
        .pix_ce       (pix_ce),
        .x            (x),
        .y            (y),
        .pal_color    (pal_color),
        .border_color (border_color),
        .video_en     (video_en),
        .pal_index    (pal_index),
        .red          (red),
        .green        (green),
        .blue         (blue),
        .hs           (hs),
        .vs           (vs)
    );

endmodule

// File: tests/video_asserts.sv
`timescale 1ns/100ps

module video_asserts (
    input logic                          osc_clock,
    input logic                          rst_n,
    input logic                          wb_cyc,
    input logic                          wb_stb,
    input logic                          wb_ack,
    input logic [video_pkg::red_w-1:0]   red,
    input logic [video_pkg::green_w-1:0] green,
    input logic [video_pkg::blue_w-1:0]  blue,
    input logic                          hs,
    input logic                          vs,
    input logic                          ppu_strobe,
    input logic                          cpu_strobe
);

    // Failed assertions so far
    int fail_count = 0;

    // ------------------------------
    // Wishbone handshake
    // ------------------------------

    ack_in_cycle: assert property (@(posedge osc_clock) disable iff (!rst_n)
        wb_ack |-> (wb_cyc && wb_stb))
        else begin
            fail_count++;
            $error("wb_ack high outside an active bus cycle");
        end

    // Ack is gone one clock after stb
    ack_drops_with_stb: assert property (@(posedge osc_clock) disable iff (!rst_n)
        !wb_stb |=> !wb_ack)
        else begin
            fail_count++;
            $error("wb_ack still high the cycle after wb_stb fell");
        end

    // ------------------------------
    // Blanking and strobes
    // ------------------------------

    black_in_sync: assert property (@(posedge osc_clock) disable iff (!rst_n)
        (hs || vs) |-> ({red, green, blue} == '0))
        else begin
            fail_count++;
            $error("RGB not black during sync");
        end

    cpu_on_ppu: assert property (@(posedge osc_clock) disable iff (!rst_n)
        cpu_strobe |-> ppu_strobe)
        else begin
            fail_count++;
            $error("cpu_strobe without ppu_strobe");
        end

endmodule

bind video_top video_asserts u_asserts (
    .osc_clock  (osc_clock),
    .rst_n      (rst_n),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_ack     (wb_ack),
    .red        (red),
    .green      (green),
    .blue       (blue),
    .hs         (hs),
    .vs         (vs),
    .ppu_strobe (ppu_strobe),
    .cpu_strobe (cpu_strobe)
);

// File: tests/video_tb.sv
`timescale 1ns/100ps

module video_tb;

    // VGA 640x480 raster and console strobe counts
    localparam int line_pix     = 800;
    localparam int frame_lines  = 525;
    localparam int hs_first     = 656;
    localparam int vs_first     = 490;
    localparam int ppu_per_line = 341;
    // CPU takes dots 1, 4, 7 and so on
    localparam int cpu_per_line = (ppu_per_line + 2) / 3;
    localparam int ack_limit    = 2;
    // Four osc cycles per pixel
    localparam int osc_per_pix  = 4;
    localparam int frame_cycles = line_pix * frame_lines * osc_per_pix;
    // Tests end early in the third frame
    localparam int cycle_limit  = frame_cycles * 12 / 5;

    logic        osc_clock;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [7:0]  wb_adr;
    logic [15:0] wb_dat_i;
    logic [15:0] wb_dat_o;
    logic        wb_ack;
    logic        vga_clock;
    logic        ppu_strobe;
    logic        cpu_strobe;
    logic [4:0]  red;
    logic [5:0]  green;
    logic [4:0]  blue;
    logic        hs;
    logic        vs;

    // Records of op, address or x, y, data
    logic [63:0] stim [64];
    logic [15:0] pal_model [32];
    int          seed = 5;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycles = 0;

    // Output raster as seen from the ports
    logic        vga_last = 1'b0;
    logic        hs_last = 1'b0;
    logic        vs_last = 1'b0;
    logic        x_ok = 1'b0;
    logic        y_ok = 1'b0;
    int          ox = 0;
    int          oy = 0;
    logic [15:0] pix_rgb;
    int          vga_osc = 0;
    int          vga_high = 0;
    int          vga_period;
    int          vga_width;
    int          h_since = 0;
    int          h_count = 0;
    int          h_period;
    int          h_width;
    int          v_lines = 0;
    int          v_count = 0;
    int          v_period;
    int          v_width;
    int          ppu_cnt = 0;
    int          cpu_cnt = 0;
    int          lone_cpu = 0;
    int          done_y;
    int          done_ppu;
    int          done_cpu;
    event        pix_tick;
    event        hs_rise;
    event        vs_rise;
    event        line_done;

    video_top dut (.*);

    initial begin
        osc_clock = 1'b0;
        forever #10 osc_clock = ~osc_clock;
    end

    always @(posedge osc_clock) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run still busy after %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    // ------------------------------
    // Pixel tracking
    // ------------------------------

    // Outputs settle at the vga_clock rise
    // They are read one osc edge later
    always @(posedge osc_clock) begin
        vga_osc++;
        if (vga_clock && !vga_last) begin
            // Divider period and duty as seen from the port
            vga_period = vga_osc;
            vga_width  = vga_high;
            vga_osc    = 0;
            vga_high   = 0;
            pix_rgb = {red, green, blue};
            if (x_ok) begin
                ox = (ox + 1) % line_pix;
            end
            if (hs && !hs_last) begin
                ox   = hs_first;
                x_ok = 1'b1;
            end
            if (x_ok && ox == 0) begin
                // Strobe counts of the line just finished
                done_y   = oy;
                done_ppu = ppu_cnt;
                done_cpu = cpu_cnt;
                ppu_cnt  = 0;
                cpu_cnt  = 0;
                oy       = (oy + 1) % frame_lines;
                -> line_done;
            end
            if (vs && !vs_last) begin
                oy       = vs_first;
                y_ok     = 1'b1;
                v_period = v_lines;
                v_width  = v_count;
                v_lines  = 0;
                v_count  = 0;
                -> vs_rise;
            end
            h_since++;
            if (hs && !hs_last) begin
                h_period = h_since;
                h_width  = h_count;
                h_since  = 0;
                h_count  = 0;
                v_lines++;
                if (vs) begin
                    v_count++;
                end
                -> hs_rise;
            end
            if (hs) begin
                h_count++;
            end
            hs_last = hs;
            vs_last = vs;
            -> pix_tick;
        end
        if (vga_clock) begin
            vga_high++;
        end
        vga_last = vga_clock;
        // Strobes land on the tick of their own pixel
        if (ppu_strobe) begin
            ppu_cnt++;
        end
        if (cpu_strobe) begin
            cpu_cnt++;
        end
        if (cpu_strobe && !ppu_strobe) begin
            lone_cpu++;
        end
    end

    // ------------------------------
    // Checks and bus access
    // ------------------------------

    task automatic mismatch(input string name, input int got, input int exp);
        $display("Mismatch at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
        errors++;
    endtask

    task automatic finish_test(input string name, input int mark);
        tests_run++;
        if (errors == mark) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: failed with %0d errors", name, errors - mark);
            tests_failed++;
        end
    endtask

    task automatic bus_access(input logic we, input logic [7:0] adr, input logic [15:0] wdata,
                              output logic [15:0] rdata, output logic acked);
        int waited;
        waited = 0;
        acked  = 1'b0;
        @(posedge osc_clock);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_i <= wdata;
        // Ack due on the second edge
        while (!acked && waited < ack_limit) begin
            @(posedge osc_clock);
            waited++;
            acked = wb_ack;
        end
        rdata = wb_dat_o;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic bus_write(input logic [7:0] adr, input logic [15:0] data);
        logic [15:0] rdata;
        logic        acked;
        bus_access(1'b1, adr, data, rdata, acked);
        if (!acked) begin
            $display("No ack within %0d cycles for write to address %0h at %0t ns",
                     ack_limit, adr, $time);
            errors++;
        end
    endtask

    task automatic bus_read_check(input logic [7:0] adr, input logic [15:0] exp);
        logic [15:0] rdata;
        logic        acked;
        bus_access(1'b0, adr, 16'h0000, rdata, acked);
        if (!acked) begin
            $display("No ack within %0d cycles for read of address %0h at %0t ns",
                     ack_limit, adr, $time);
            errors++;
        end else if (rdata !== exp) begin
            mismatch($sformatf("wb_dat_o at address %0h", adr), rdata, exp);
        end
    endtask

    task automatic pixel_check(input int px, input int py, input logic [15:0] exp);
        do @(pix_tick); while (!(x_ok && y_ok && ox == px && oy == py));
        if (pix_rgb !== exp) begin
            mismatch($sformatf("rgb at (%0d,%0d)", px, py), pix_rgb, exp);
        end
    endtask

    // Runs records up to the next op 0
    task automatic replay(inout int idx);
        logic [15:0] op;
        logic [15:0] a;
        logic [15:0] py;
        logic [15:0] d;
        int          done;
        done = 0;
        while (idx < 64 && stim[idx][63:48] != 16'h0000) begin
            {op, a, py, d} = stim[idx];
            case (op)
                16'h0001: bus_write(a[7:0], d);
                16'h0002: bus_read_check(a[7:0], d);
                16'h0003: pixel_check(a, py, d);
                16'h0004: pixel_check(a, py, pal_model[d[4:0]]);
                default: begin
                    $display("Unknown stimulus op %0h in record %0d", op, idx);
                    errors++;
                end
            endcase
            idx++;
            done++;
        end
        if (done == 0) begin
            $display("Stimulus segment at record %0d holds no records", idx);
            errors++;
        end
        idx++;
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------

    initial begin
        int mark;
        int idx;
        int exp_ppu;
        int exp_cpu;
        int asserts_failed;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = 8'h00;
        wb_dat_i = 16'h0000;
        rst_n    = 1'b0;
        for (int i = 0; i < 64; i++) begin
            stim[i] = 64'h0;
        end
        $readmemh("tests/video_stim.mem", stim);
        repeat (10) @(posedge osc_clock);
        rst_n <= 1'b1;

        // Random palette, then border, control and unmapped from the file
        mark = errors;
        idx  = 0;
        for (int i = 0; i < 32; i++) begin
            pal_model[i] = 16'($random(seed));
            bus_write(8'(i), pal_model[i]);
        end
        replay(idx);
        for (int i = 0; i < 32; i++) begin
            bus_read_check(8'(i), pal_model[i]);
        end
        finish_test("register write and read-back", mark);

        // First rise closes a partial line
        mark = errors;
        @(hs_rise);
        @(hs_rise);
        if (h_period != line_pix) mismatch("hs period", h_period, line_pix);
        if (h_width != 96) mismatch("hs width", h_width, 96);
        if (vga_period != osc_per_pix) mismatch("vga_clock period", vga_period, osc_per_pix);
        if (vga_width != osc_per_pix / 2) mismatch("vga_clock high", vga_width, osc_per_pix / 2);
        finish_test("horizontal timing", mark);

        mark = errors;
        @(vs_rise);
        @(vs_rise);
        if (v_period != frame_lines) mismatch("vs period in lines", v_period, frame_lines);
        if (v_width != 2) mismatch("vs width in lines", v_width, 2);
        finish_test("vertical timing", mark);

        // Only even lines carry the console dots
        mark = errors;
        repeat (4) begin
            @(line_done);
            exp_ppu = (done_y % 2 == 0) ? ppu_per_line : 0;
            exp_cpu = (done_y % 2 == 0) ? cpu_per_line : 0;
            if (done_ppu != exp_ppu) begin
                mismatch($sformatf("ppu_strobe count on line %0d", done_y), done_ppu, exp_ppu);
            end
            if (done_cpu != exp_cpu) begin
                mismatch($sformatf("cpu_strobe count on line %0d", done_y), done_cpu, exp_cpu);
            end
        end
        if (lone_cpu != 0) begin
            $display("cpu_strobe pulsed %0d times without ppu_strobe", lone_cpu);
            errors++;
        end
        finish_test("console strobes", mark);

        mark = errors;
        replay(idx);
        finish_test("pixel colour", mark);

        asserts_failed = dut.u_asserts.fail_count;
        $display("Summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
                 tests_run, tests_failed, errors, asserts_failed);
        if (tests_failed == 0 && errors == 0 && asserts_failed == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: tests/video_stim.mem
// Columns: op, address or pixel x, pixel y, data (16-bit hex fields)
// op 1 write, 2 read and compare, 3 pixel equals data, 4 pixel equals palette entry data, 0 ends
// Register segment: border, control, unmapped addresses
0001_0020_0000_7bef
0001_0021_0000_0001
0002_0020_0000_7bef
0002_0021_0000_0001
0002_0040_0000_0000
0001_0041_0000_1234
0002_0041_0000_0000
0000_0000_0000_0000
// Pixel segment: bars on line 20, border and blanking on line 21, enable off by line 23
0004_0046_0014_0000
0004_012c_0014_000e
0004_023f_0014_001f
0003_000a_0015_7bef
0003_0258_0015_7bef
0003_02bc_0015_0000
0001_0021_0000_0000
0003_012c_0017_7bef
0000_0000_0000_0000

// File: all.f
rtl/video_pkg.sv
rtl/wb_video_regs.sv
rtl/raster_timing.sv
rtl/pixel_output.sv
rtl/video_top.sv
tests/video_asserts.sv
tests/video_tb.sv

// File: Bender.yml
package:
  name: video_front_end

sources:
  - rtl/video_pkg.sv
  - rtl/wb_video_regs.sv
  - rtl/raster_timing.sv
  - rtl/pixel_output.sv
  - rtl/video_top.sv
  - target: test
    files:
      - tests/video_asserts.sv
      - tests/video_tb.sv
